/* hdl/ahci_rx_config.svh */
// AHCI receive configuration
`ifndef AHCI_RX_CONFIG_SVH
`define AHCI_RX_CONFIG_SVH

`define AHCI_ADDR_BITS     10      // register dword address width

// register space, all offsets in dwords
`define AHCI_FB_OFFS32     'h300   // FIS receive area base
`define AHCI_RFIS32        'h10    // D2H register FIS slot
`define AHCI_SDBFIS32      'h16    // set device bits FIS slot
`define AHCI_PXTFD_OFFS32  'h48    // port 0 task file data
`define AHCI_PXSIG_OFFS32  'h49    // port 0 signature

// FIS lengths in dwords, minus one
`define AHCI_RFIS_LENM1    4
`define AHCI_SDBFIS_LENM1  1
`define AHCI_IGNORE_LENM1  15      // longest FIS that can be skipped

`define AHCI_DWCNT_BITS    12      // data FIS dword counter width

`endif

/* hdl/ahci_rx_pkg.sv */
// AHCI receive types
`include "ahci_rx_config.svh"

package ahci_rx_pkg;

    typedef logic [31:0] dword_t;                        // transport / register word
    typedef logic [`AHCI_ADDR_BITS-1:0] reg_addr_t;      // register dword address

    // tag attached to each word by the transport FIFO
    typedef enum logic [1:0] {
        TAG_DMA   = 2'd0,   // payload or FIS body
        TAG_HEAD  = 2'd1,   // first dword of a FIS
        TAG_R_OK  = 2'd2,   // end, crc good
        TAG_R_ERR = 2'd3    // end, crc or transport error
    } word_tag_e;

    typedef enum logic [2:0] {
        KIND_NONE,
        KIND_RFIS,          // D2H register
        KIND_SDB,           // set device bits
        KIND_DATA,
        KIND_IGNORE
    } fis_kind_e;

    typedef struct packed {
        logic [7:0] err;    // PxTFD.ERR
        logic [7:0] sts;    // PxTFD.STS, bit 7 BSY, bit 3 DRQ
    } tfd_t;

    typedef logic [`AHCI_DWCNT_BITS-1:0] dwcnt_t;

    function automatic logic tag_is_end(input word_tag_e tag);
        return (tag == TAG_R_OK) || (tag == TAG_R_ERR);   // either end closes the FIS
    endfunction

endpackage

/* hdl/fis_stream_if.sv */
// FIS word stream
`timescale 1ns/10ps

interface fis_stream_if import ahci_rx_pkg::*; ();

    dword_t    word;        // FIFO output word
    word_tag_e tag;         // its transport tag
    logic      avail;       // word may be taken this cycle
    logic      end_seen;    // end word first seen
    logic      store_take;  // consumed by the store sequencer
    logic      dma_take;    // consumed by the DMA forwarder

    modport src (
        output word, tag, avail, end_seen,
        input  store_take, dma_take
    );

    modport store_sink (
        input  word, tag, avail, end_seen,
        output store_take
    );

    modport dma_sink (
        input  word, tag, avail,
        output dma_take
    );

endinterface

/* hdl/fis_frame_ctrl.sv */
// FIS frame control
`timescale 1ns/10ps

module fis_frame_ctrl import ahci_rx_pkg::*; (
    input  logic       mclk,
    input  logic       hba_rst,
    input  logic       pcmd_st_cleared,
    input  logic       get_any,             // any get_* command
    input  logic       fatal,               // sticky overrun error
    input  dword_t     hba_data_in,
    input  logic [1:0] hba_data_in_type,
    input  logic       hba_data_in_valid,
    input  logic       hba_data_in_many,
    output logic       hba_data_in_ready,
    fis_stream_if.src  stream,
    output logic       fis_first_vld,
    output logic       get_fis_busy,
    output logic       get_fis_done,
    output logic       fis_ok,
    output logic       fis_err
);

    logic [1:0] was_read;   // consume history, hides FIFO read latency
    logic [1:0] end_r;      // end word stage, [0] consumes it

    assign stream.word       = hba_data_in;
    assign stream.tag        = word_tag_e'(hba_data_in_type);
    assign stream.avail      = hba_data_in_valid && (hba_data_in_many || !(|was_read));
    assign stream.end_seen   = stream.avail && tag_is_end(stream.tag) && !(|end_r); // once per end
    assign hba_data_in_ready = stream.store_take || stream.dma_take || end_r[0];

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            was_read <= 2'b00;
            end_r    <= 2'b00;
        end else begin
            was_read <= {was_read[0], hba_data_in_ready};
            end_r    <= {end_r[0], stream.end_seen};
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst || pcmd_st_cleared)     get_fis_busy <= 1'b0;
        else if (get_any)                   get_fis_busy <= 1'b1;
        else if (fatal || stream.end_seen)  get_fis_busy <= 1'b0;   // drops with done

        if (hba_rst) get_fis_done <= 1'b0;
        else         get_fis_done <= get_fis_busy && (fatal || stream.end_seen);

        if (hba_rst || get_any)             fis_ok <= 1'b0;
        else if (stream.end_seen)           fis_ok <= (stream.tag == TAG_R_OK);

        if (hba_rst || get_any)             fis_err <= 1'b0;
        else if (stream.end_seen)           fis_err <= (stream.tag == TAG_R_ERR);

        // head waiting for a command, hidden while a FIS is processed
        if (hba_rst || pcmd_st_cleared || get_any || get_fis_busy)
            fis_first_vld <= 1'b0;
        else if (stream.avail && stream.tag == TAG_HEAD)
            fis_first_vld <= 1'b1;
    end

endmodule

/* hdl/fis_store_seq.sv */
// FIS store sequencer
`timescale 1ns/10ps
`include "ahci_rx_config.svh"

module fis_store_seq import ahci_rx_pkg::*; (
    input  logic             mclk,
    input  logic             hba_rst,
    input  logic             pcmd_st_cleared,
    input  logic             pcmd_fre,        // FIS receive enable
    input  logic             sig_pending,     // register FIS always stored
    input  logic             get_rfis,
    input  logic             get_sdbfis,
    input  logic             get_data_fis,
    input  logic             get_ignore,
    fis_stream_if.store_sink stream,
    output logic             store_we,
    output reg_addr_t        store_addr,
    output dword_t           store_word,
    output logic [4:0]       rfis_pos,        // one-hot register FIS word
    output logic [1:0]       sdb_pos,         // one-hot SDB FIS word
    output logic             data_start,      // data FIS header taken
    output logic             too_long         // word beyond the slot
);

    localparam reg_addr_t  RFIS_ADDR = reg_addr_t'(`AHCI_FB_OFFS32 + `AHCI_RFIS32);
    localparam reg_addr_t  SDB_ADDR  = reg_addr_t'(`AHCI_FB_OFFS32 + `AHCI_SDBFIS32);
    localparam logic [3:0] RFIS_LEN  = 4'(`AHCI_RFIS_LENM1);
    localparam logic [3:0] SDB_LEN   = 4'(`AHCI_SDBFIS_LENM1);
    localparam logic [3:0] IGN_LEN   = 4'(`AHCI_IGNORE_LENM1);

    fis_kind_e  kind;
    reg_addr_t  addr_r;     // next slot address
    logic [3:0] left;       // words left minus one
    logic [4:0] pos;        // one-hot word position
    logic       save;       // write words to the receive area
    logic       run;
    logic       over;       // slot used up
    logic       get_any;
    logic       take;
    logic       extra;

    assign get_any = get_rfis || get_sdbfis || get_data_fis || get_ignore;
    assign take    = run && !over && stream.avail && !tag_is_end(stream.tag);
    assign extra   = run && over && stream.avail && !tag_is_end(stream.tag);

    assign stream.store_take = take;
    assign store_we          = take && save;
    assign store_addr        = addr_r;
    assign store_word        = stream.word;
    assign rfis_pos          = (take && kind == KIND_RFIS) ? pos : 5'd0;
    assign sdb_pos           = (take && kind == KIND_SDB) ? pos[1:0] : 2'd0;
    assign data_start        = take && kind == KIND_DATA;  // only the header is ours

    always_ff @(posedge mclk) begin
        if (hba_rst || pcmd_st_cleared) begin
            run  <= 1'b0;
            over <= 1'b0;
            kind <= KIND_NONE;
        end else if (get_any) begin
            run  <= 1'b1;
            over <= 1'b0;
            kind <= get_rfis     ? KIND_RFIS :
                    get_sdbfis   ? KIND_SDB  :
                    get_data_fis ? KIND_DATA : KIND_IGNORE;
        end else begin
            if (take && left == 4'd0) over <= 1'b1;
            if (stream.end_seen || extra || data_start) run <= 1'b0; // DMA owns the rest
        end

        if (hba_rst) too_long <= 1'b0;
        else         too_long <= extra;   // one pulse, run stops
    end

    always_ff @(posedge mclk) begin
        if (get_any) begin
            addr_r <= get_sdbfis ? SDB_ADDR : RFIS_ADDR;
            left   <= get_rfis   ? RFIS_LEN :
                      get_sdbfis ? SDB_LEN  :
                      get_ignore ? IGN_LEN  : 4'd0;  // data FIS header is one word
            pos    <= 5'b00001;
            save   <= (sig_pending && get_rfis) || (pcmd_fre && (get_rfis || get_sdbfis));
        end else if (take) begin
            if (left != 4'd0) left <= left - 4'd1;
            if (save)         addr_r <= addr_r + 1'b1;
            pos <= pos << 1;
        end
    end

endmodule

/* hdl/tfd_sig_tracker.sv */
// Task file and signature tracker
`timescale 1ns/10ps

module tfd_sig_tracker import ahci_rx_pkg::*; (
    input  logic       mclk,
    input  logic       hba_rst,
    input  dword_t     word,            // word being taken
    input  logic [4:0] rfis_pos,
    input  logic [1:0] sdb_pos,
    input  logic       set_update_sig,  // arm signature update
    input  logic       update_sig,
    input  logic       set_bsy,
    input  logic       clear_bsy_drq,
    output tfd_t       tfd,
    output dword_t     sig,
    output logic       pUpdateSig,      // signature pending
    output logic       sig_available,
    output logic       fis_i,
    output logic       sdb_n,
    output logic       sactive0
);

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            tfd <= '0;
        end else if (rfis_pos[0]) begin
            tfd <= tfd_t'(word[31:16]);                          // error and status bytes
        end else if (sdb_pos[0]) begin
            tfd.err <= word[31:24];
            tfd.sts <= {tfd.sts[7], word[22:20], tfd.sts[3], word[18:16]}; // BSY, DRQ kept
        end else begin
            if (set_bsy) tfd.sts[7] <= 1'b1;
            if (clear_bsy_drq) begin
                tfd.sts[7] <= 1'b0;
                tfd.sts[3] <= 1'b0;
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (rfis_pos[1]) sig[31:8] <= word[23:0];    // lba low/mid/high
        if (rfis_pos[3]) sig[7:0]  <= word[7:0];     // sector count

        if (hba_rst || set_update_sig) pUpdateSig <= 1'b1;
        else if (update_sig)           pUpdateSig <= 1'b0;

        if (hba_rst || update_sig)     sig_available <= 1'b0;
        else if (rfis_pos[3])          sig_available <= 1'b1;

        if (rfis_pos[0] || sdb_pos[0]) fis_i <= word[14];
        if (sdb_pos[0])                sdb_n <= word[15];
        if (sdb_pos[1])                sactive0 <= word[0];
    end

endmodule

/* hdl/port_reg_writer.sv */
// Port register writer
`timescale 1ns/10ps
`include "ahci_rx_config.svh"

module port_reg_writer import ahci_rx_pkg::*; (
    input  logic      mclk,
    input  logic      hba_rst,
    input  logic      store_we,
    input  reg_addr_t store_addr,
    input  dword_t    store_word,
    input  tfd_t      tfd,
    input  dword_t    sig,
    input  logic      pUpdateSig,
    input  logic      update_err_sts,
    input  logic      set_bsy,
    input  logic      clear_bsy_drq,
    input  logic      update_sig,
    output reg_addr_t reg_addr,
    output logic      reg_we,
    output dword_t    reg_data
);

    localparam reg_addr_t TFD_ADDR = reg_addr_t'(`AHCI_PXTFD_OFFS32);
    localparam reg_addr_t SIG_ADDR = reg_addr_t'(`AHCI_PXSIG_OFFS32);

    logic upd_tfd_r;    // tfd settles one cycle after the command
    logic upd_sig_r;

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            upd_tfd_r <= 1'b0;
            upd_sig_r <= 1'b0;
            reg_we    <= 1'b0;
        end else begin
            upd_tfd_r <= update_err_sts || set_bsy || clear_bsy_drq;
            upd_sig_r <= update_sig && pUpdateSig;          // only when pending
            reg_we    <= store_we || upd_tfd_r || upd_sig_r;
        end
    end

    always_ff @(posedge mclk) begin
        if (store_we) begin                  // stored FIS words win
            reg_addr <= store_addr;
            reg_data <= store_word;
        end else if (upd_tfd_r) begin
            reg_addr <= TFD_ADDR;
            reg_data <= {16'h0000, tfd};
        end else if (upd_sig_r) begin
            reg_addr <= SIG_ADDR;
            reg_data <= sig;
        end
    end

endmodule

/* hdl/dma_rx_forward.sv */
// Data FIS forwarder
`timescale 1ns/10ps
`include "ahci_rx_config.svh"

module dma_rx_forward import ahci_rx_pkg::*; (
    input  logic           mclk,
    input  logic           hba_rst,
    input  logic           pcmd_st_cleared,
    input  logic           data_start,      // header taken and payload follows
    input  logic           fatal_in,        // overlong stored FIS
    input  logic           dma_in_ready,
    fis_stream_if.dma_sink stream,
    output logic           dma_in_valid,
    output dwcnt_t         data_in_dwords,
    output logic           dma_too_long     // sticky fatal error
);

    logic   fwd;        // payload forwarding active
    dwcnt_t cnt;
    logic   ferr;
    logic   take;

    assign take = fwd && dma_in_ready && stream.avail && stream.tag == TAG_DMA && !ferr;

    assign stream.dma_take = take;
    assign dma_in_valid    = take;
    assign data_in_dwords  = cnt;
    assign dma_too_long    = ferr;

    always_ff @(posedge mclk) begin
        if (hba_rst || pcmd_st_cleared)                    fwd <= 1'b0;
        else if (data_start)                               fwd <= 1'b1;
        else if (fwd && stream.avail && stream.tag != TAG_DMA) fwd <= 1'b0; // end word

        if (hba_rst || data_start) cnt <= '0;
        else if (take)             cnt <= cnt + 1'b1;

        // overflow or stored FIS overrun held until reset
        if (hba_rst)                                              ferr <= 1'b0;
        else if (fatal_in || (take && cnt[`AHCI_DWCNT_BITS-1]))   ferr <= 1'b1;
    end

endmodule

/* hdl/ahci_fis_receive.sv */
// AHCI FIS receive
`timescale 1ns/10ps

module ahci_fis_receive import ahci_rx_pkg::*; (
    input  logic       mclk,
    input  logic       hba_rst,
    input  logic       pcmd_st_cleared,
    input  logic       pcmd_fre,
    input  logic       get_rfis,
    input  logic       get_sdbfis,
    input  logic       get_data_fis,
    input  logic       get_ignore,
    input  logic       set_update_sig,
    input  logic       update_sig,
    input  logic       update_err_sts,
    input  logic       set_bsy,
    input  logic       clear_bsy_drq,
    // transport FIFO
    input  dword_t     hba_data_in,
    input  logic [1:0] hba_data_in_type,
    input  logic       hba_data_in_valid,
    input  logic       hba_data_in_many,
    output logic       hba_data_in_ready,
    // DMA engine
    input  logic       dma_in_ready,
    output logic       dma_in_valid,
    // status
    output logic       fis_first_vld,
    output logic       get_fis_busy,
    output logic       get_fis_done,
    output logic       fis_ok,
    output logic       fis_err,
    output logic       fis_ferr,
    output logic       pUpdateSig,
    output logic       sig_available,
    output logic [7:0] tfd_sts,
    output logic [7:0] tfd_err,
    output logic       fis_i,
    output logic       sdb_n,
    output logic       sactive0,
    output dwcnt_t     data_in_dwords,
    // register write port
    output reg_addr_t  reg_addr,
    output logic       reg_we,
    output dword_t     reg_data
);

    fis_stream_if rx_stream ();

    logic       get_any;
    logic       fatal;
    logic       store_we;
    reg_addr_t  store_addr;
    dword_t     store_word;
    logic [4:0] rfis_pos;
    logic [1:0] sdb_pos;
    logic       data_start;
    logic       store_too_long;
    tfd_t       tfd;
    dword_t     sig;

    assign get_any  = get_rfis || get_sdbfis || get_data_fis || get_ignore;
    assign tfd_sts  = tfd.sts;
    assign tfd_err  = tfd.err;
    assign fis_ferr = fatal;

    fis_frame_ctrl fis_frame_ctrl_i (.*, .stream(rx_stream.src));

    fis_store_seq fis_store_seq_i (
        .*,
        .sig_pending (pUpdateSig),
        .stream      (rx_stream.store_sink),
        .too_long    (store_too_long)
    );

    tfd_sig_tracker tfd_sig_tracker_i (.*, .word(rx_stream.word));

    port_reg_writer port_reg_writer_i (.*);

    dma_rx_forward dma_rx_forward_i (
        .*,
        .fatal_in     (store_too_long),
        .stream       (rx_stream.dma_sink),
        .dma_too_long (fatal)
    );

endmodule

/* testbench/tb_clk_gen.sv */
// Testbench clock and reset
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter real PERIOD_NS  = 4.0,
    parameter int  RST_CYCLES = 10
) (
    output logic mclk,
    output logic hba_rst
);

    initial begin
        mclk = 1'b0;
        forever #(PERIOD_NS / 2.0) mclk = ~mclk;
    end

    initial begin
        hba_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge mclk);
        @(negedge mclk);
        hba_rst = 1'b0;     // released away from the active edge
    end

endmodule

/* testbench/tb_ahci_fis_receive.sv */
// AHCI FIS receive testbench
`timescale 1ns/10ps
`include "ahci_rx_config.svh"

module tb_ahci_fis_receive import ahci_rx_pkg::*; ();

    localparam int NUM_TESTS       = 7;
    localparam int CYCLES_PER_TEST = 2000;
    localparam int WAIT_CYCLES     = 500;    // limit of one wait
    localparam int DATA_LEN        = 20;     // data FIS payload dwords
    localparam int W_HEAD          = 0;
    localparam int W_DONE          = 1;
    localparam int W_WRITES        = 2;
    localparam int W_EMPTY         = 3;
    localparam reg_addr_t RFIS_ADDR = reg_addr_t'(`AHCI_FB_OFFS32 + `AHCI_RFIS32);
    localparam reg_addr_t SDB_ADDR  = reg_addr_t'(`AHCI_FB_OFFS32 + `AHCI_SDBFIS32);
    localparam reg_addr_t TFD_ADDR  = reg_addr_t'(`AHCI_PXTFD_OFFS32);
    localparam reg_addr_t SIG_ADDR  = reg_addr_t'(`AHCI_PXSIG_OFFS32);

    logic       mclk, hba_rst;
    logic       pcmd_st_cleared, pcmd_fre;
    logic       get_rfis, get_sdbfis, get_data_fis, get_ignore;
    logic       set_update_sig, update_sig, update_err_sts, set_bsy, clear_bsy_drq;
    dword_t     hba_data_in;
    logic [1:0] hba_data_in_type;
    logic       hba_data_in_valid, hba_data_in_many, hba_data_in_ready;
    logic       dma_in_ready, dma_in_valid;
    logic       fis_first_vld, get_fis_busy, get_fis_done, fis_ok, fis_err, fis_ferr;
    logic       pUpdateSig, sig_available, fis_i, sdb_n, sactive0;
    logic [7:0] tfd_sts, tfd_err;
    dwcnt_t     data_in_dwords;
    reg_addr_t  reg_addr;
    logic       reg_we;
    dword_t     reg_data;

    dword_t    fifo_word[$];    // transport FIFO contents
    word_tag_e fifo_tag[$];
    dword_t    sent[$];         // non-end words of the current FIS
    reg_addr_t wr_addr[$];      // seen register writes
    dword_t    wr_data[$];
    dword_t    dma_seen[$];     // words handed to DMA
    logic      consumed;        // ready seen before the last rising edge
    logic      dma_random;      // random dma_in_ready gaps
    dword_t    rnd_bits;
    logic [31:0] rng_state = 32'd25496;
    tfd_t      exp_tfd;
    string     cur_test;
    int        checks, errors, tests_run, tests_bad, err_before;
    event      sample_ev;       // outputs sampled for this cycle

    tb_clk_gen clk_gen_i (.mclk(mclk), .hba_rst(hba_rst));

    ahci_fis_receive ahci_fis_receive_i (.*);

    function automatic dword_t xorshift32();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // FIFO model and monitor on the falling edge
    always @(negedge mclk) begin
        if (consumed) begin
            void'(fifo_word.pop_front());
            void'(fifo_tag.pop_front());
        end
        hba_data_in_valid = fifo_word.size() != 0;
        hba_data_in_many  = fifo_word.size() > 2;            // read latency hidden
        hba_data_in       = (fifo_word.size() != 0) ? fifo_word[0] : '0;
        hba_data_in_type  = (fifo_tag.size() != 0) ? fifo_tag[0] : TAG_DMA;
        #1;
        consumed = hba_data_in_ready;                        // taken at next rising edge
        if (dma_in_valid === 1'b1) begin
            check_bit("dma_in_ready with dma_in_valid", 1'b1, dma_in_ready);
            dma_seen.push_back(hba_data_in);
        end
        if (reg_we === 1'b1) begin
            wr_addr.push_back(reg_addr);
            wr_data.push_back(reg_data);
        end
        ->sample_ev;
    end

    always @(negedge mclk) begin
        if (dma_random) begin
            rnd_bits = xorshift32();
            dma_in_ready = rnd_bits[4];                      // about half the cycles
        end else begin
            dma_in_ready = 1'b0;
        end
    end

    task automatic record_check(input bit ok, input string what, input string e, input string a);
        checks++;
        if (!ok) begin
            errors++;
            $display("FAILED %s %s: expected %s, actual %s", cur_test, what, e, a);
        end
    endtask

    task automatic check_dword(input string what, input dword_t exp, input dword_t act);
        record_check(act === exp, what, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_addr(input string what, input reg_addr_t exp, input reg_addr_t act);
        record_check(act === exp, what, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_tfd(input string what, input tfd_t exp, input tfd_t act);
        record_check(act === exp, what, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        record_check(act === exp, what, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic check_count(input string what, input dwcnt_t exp, input dwcnt_t act);
        record_check(act === exp, what, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask

    function automatic bit wait_cond(input int what, input int nwr);
        case (what)
            W_HEAD:   return fis_first_vld === 1'b1;
            W_DONE:   return get_fis_done === 1'b1;
            W_WRITES: return wr_addr.size() >= nwr;
            default:  return fifo_word.size() == 0;
        endcase
    endfunction

    task automatic wait_for(input int what, input int nwr, input string desc);
        int n;
        n = 0;
        while (!wait_cond(what, nwr) && n < WAIT_CYCLES) begin
            @(sample_ev);
            n++;
        end
        if (!wait_cond(what, nwr)) begin
            errors++;
            $display("%s: timed out waiting for %s", cur_test, desc);
        end
    endtask

    task automatic clear_monitor();
        @(sample_ev);                                        // no push in flight
        wr_addr.delete();
        wr_data.delete();
        dma_seen.delete();
    endtask

    // {update_sig, update_err_sts, clear_bsy_drq, set_bsy} for one cycle
    task automatic pulse_cmd(input logic [3:0] sel);
        @(negedge mclk);
        {update_sig, update_err_sts, clear_bsy_drq, set_bsy} = sel;
        @(negedge mclk);
        {update_sig, update_err_sts, clear_bsy_drq, set_bsy} = 4'b0000;
    endtask

    task automatic run_fis(input fis_kind_e kind, input int len, input word_tag_e end_tag,
                           input logic fre, input bit drain);
        clear_monitor();
        sent.delete();
        for (int i = 0; i < len; i++) begin
            sent.push_back(xorshift32());
            fifo_word.push_back(sent[i]);
            fifo_tag.push_back(i == 0 ? TAG_HEAD : TAG_DMA);
        end
        fifo_word.push_back(xorshift32());                   // end word with an unused value
        fifo_tag.push_back(end_tag);
        wait_for(W_HEAD, 0, "a waiting FIS head");
        @(negedge mclk);
        pcmd_fre = fre;
        case (kind)
            KIND_RFIS: get_rfis = 1'b1;
            KIND_SDB:  get_sdbfis = 1'b1;
            KIND_DATA: get_data_fis = 1'b1;
            default:   get_ignore = 1'b1;
        endcase
        @(negedge mclk);
        {get_rfis, get_sdbfis, get_data_fis, get_ignore} = 4'b0000;
        wait_for(W_DONE, 0, "get_fis_done");
        check_bit("fis_first_vld", 1'b0, fis_first_vld);
        if (drain) wait_for(W_EMPTY, 0, "the end word to be consumed");
    endtask

    task automatic check_writes(input reg_addr_t base, input int n);
        check_count("write count", dwcnt_t'(n), dwcnt_t'(wr_addr.size()));
        for (int i = 0; i < n && i < wr_addr.size(); i++) begin
            check_addr("write address", base + reg_addr_t'(i), wr_addr[i]);
            check_dword("write data", sent[i], wr_data[i]);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test   = name;
        err_before = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors > err_before) begin
            tests_bad++;
            $display("test %s: %0d errors", cur_test, errors - err_before);
        end else begin
            $display("test %s: passed", cur_test);
        end
    endtask

    task automatic reset_values();
        begin_test("reset_values");
        check_bit("reg_we", 1'b0, reg_we);
        check_bit("get_fis_busy", 1'b0, get_fis_busy);
        check_bit("get_fis_done", 1'b0, get_fis_done);
        check_bit("fis_ok", 1'b0, fis_ok);
        check_bit("fis_err", 1'b0, fis_err);
        check_bit("fis_ferr", 1'b0, fis_ferr);
        check_bit("dma_in_valid", 1'b0, dma_in_valid);
        check_bit("hba_data_in_ready", 1'b0, hba_data_in_ready);
        check_bit("sig_available", 1'b0, sig_available);
        check_bit("fis_first_vld", 1'b0, fis_first_vld);
        check_bit("pUpdateSig", 1'b1, pUpdateSig);
        end_test();
    endtask

    task automatic rfis_stored();
        dword_t exp_sig;
        begin_test("rfis_stored");
        run_fis(KIND_RFIS, 5, TAG_R_OK, 1'b1, 1'b1);
        check_writes(RFIS_ADDR, 5);
        check_bit("fis_ok", 1'b1, fis_ok);
        check_bit("fis_err", 1'b0, fis_err);
        exp_tfd = tfd_t'(sent[0][31:16]);                   // error and status of word 0
        check_tfd("tfd", exp_tfd, tfd_t'({tfd_err, tfd_sts}));
        check_bit("sig_available", 1'b1, sig_available);
        exp_sig = {sent[1][23:0], sent[3][7:0]};
        pulse_cmd(4'b1000);
        wait_for(W_WRITES, 6, "the PxSIG write");
        if (wr_addr.size() >= 6) begin
            check_addr("sig address", SIG_ADDR, wr_addr[5]);
            check_dword("sig data", exp_sig, wr_data[5]);
        end
        check_bit("sig_available", 1'b0, sig_available);
        check_bit("pUpdateSig", 1'b0, pUpdateSig);
        end_test();
    endtask

    task automatic rfis_not_stored();
        begin_test("rfis_not_stored");
        run_fis(KIND_RFIS, 5, TAG_R_ERR, 1'b0, 1'b1);        // receive off and no sig pending
        check_writes(RFIS_ADDR, 0);
        exp_tfd = tfd_t'(sent[0][31:16]);
        check_tfd("tfd", exp_tfd, tfd_t'({tfd_err, tfd_sts}));
        check_bit("fis_err", 1'b1, fis_err);
        check_bit("fis_ok", 1'b0, fis_ok);
        end_test();
    endtask

    task automatic sdb_fis();
        begin_test("sdb_fis");
        run_fis(KIND_SDB, 2, TAG_R_OK, 1'b1, 1'b1);
        exp_tfd.err = sent[0][31:24];
        exp_tfd.sts = (exp_tfd.sts & 8'h88) | (sent[0][23:16] & 8'h77);  // BSY and DRQ kept
        check_tfd("tfd", exp_tfd, tfd_t'({tfd_err, tfd_sts}));
        check_bit("sdb_n", sent[0][15], sdb_n);
        check_bit("fis_i", sent[0][14], fis_i);
        check_bit("sactive0", sent[1][0], sactive0);
        check_writes(SDB_ADDR, 2);
        end_test();
    endtask

    task automatic tfd_commands();
        begin_test("tfd_commands");
        for (int op = 0; op < 3; op++) begin                // set_bsy, clear_bsy_drq, update
            if (op == 0) exp_tfd.sts[7] = 1'b1;
            if (op == 1) begin
                exp_tfd.sts[7] = 1'b0;
                exp_tfd.sts[3] = 1'b0;
            end
            clear_monitor();
            pulse_cmd(4'b0001 << op);
            wait_for(W_WRITES, 1, "the PxTFD write");
            check_count("write count", dwcnt_t'(1), dwcnt_t'(wr_addr.size()));
            if (wr_addr.size() != 0) begin
                check_addr("tfd address", TFD_ADDR, wr_addr[0]);
                check_dword("tfd data", {16'h0000, exp_tfd}, wr_data[0]);
            end
            check_tfd("tfd", exp_tfd, tfd_t'({tfd_err, tfd_sts}));
        end
        end_test();
    endtask

    task automatic data_fis();
        begin_test("data_fis");
        dma_random = 1'b1;
        run_fis(KIND_DATA, DATA_LEN + 1, TAG_R_OK, 1'b1, 1'b1); // header plus payload
        dma_random = 1'b0;
        check_count("dma words", dwcnt_t'(DATA_LEN), dwcnt_t'(dma_seen.size()));
        for (int i = 0; i < DATA_LEN && i < dma_seen.size(); i++)
            check_dword("dma word", sent[i + 1], dma_seen[i]);
        check_count("data_in_dwords", dwcnt_t'(DATA_LEN), data_in_dwords);
        check_writes(RFIS_ADDR, 0);
        check_bit("fis_ok", 1'b1, fis_ok);
        end_test();
    endtask

    task automatic rfis_too_long();
        begin_test("rfis_too_long");
        run_fis(KIND_RFIS, 7, TAG_R_OK, 1'b1, 1'b0);         // leftover words stay queued
        check_bit("fis_ferr", 1'b1, fis_ferr);
        check_bit("get_fis_busy", 1'b0, get_fis_busy);
        check_writes(RFIS_ADDR, 5);
        end_test();
    endtask

    initial begin
        {pcmd_st_cleared, pcmd_fre, get_rfis, get_sdbfis, get_data_fis, get_ignore} = '0;
        {set_update_sig, update_sig, update_err_sts, set_bsy, clear_bsy_drq} = '0;
        hba_data_in       = '0;
        hba_data_in_type  = 2'b00;
        hba_data_in_valid = 1'b0;
        hba_data_in_many  = 1'b0;
        dma_in_ready      = 1'b0;
        dma_random        = 1'b0;
        consumed          = 1'b0;
        checks    = 0;
        errors    = 0;
        tests_run = 0;
        tests_bad = 0;
        @(negedge hba_rst);
        @(sample_ev);
        reset_values();
        rfis_stored();
        rfis_not_stored();
        sdb_fis();
        tfd_commands();
        data_fis();
        rfis_too_long();
        $display("%0d tests, %0d with errors, %0d checks, %0d errors",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    // watchdog
    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge mclk);
        $display("watchdog: tests did not finish within %0d cycles",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* flist.f */
+incdir+hdl
hdl/ahci_rx_pkg.sv
hdl/fis_stream_if.sv
hdl/fis_frame_ctrl.sv
hdl/fis_store_seq.sv
hdl/tfd_sig_tracker.sv
hdl/port_reg_writer.sv
hdl/dma_rx_forward.sv
hdl/ahci_fis_receive.sv
testbench/tb_clk_gen.sv
testbench/tb_ahci_fis_receive.sv

/* Bender.yml */
package:
  name: ahci_fis_receive

export_include_dirs:
  - hdl

sources:
  - hdl/ahci_rx_pkg.sv
  - hdl/fis_stream_if.sv
  - hdl/fis_frame_ctrl.sv
  - hdl/fis_store_seq.sv
  - hdl/tfd_sig_tracker.sv
  - hdl/port_reg_writer.sv
  - hdl/dma_rx_forward.sv
  - hdl/ahci_fis_receive.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_ahci_fis_receive.sv
